// File: design/sdram_map_pkg.sv
// SDRAM memory map definitions
`default_nettype none

package sdram_map_pkg;

    // Word address into the SDRAM
    typedef logic [21:0] sdram_addr_t;

    // Address as seen by one client slot
    typedef logic [19:0] slot_addr_t;

    // Slot payloads
    typedef logic [7:0]  snd_word_t;
    typedef logic [31:0] gfx_word_t;

    // Download stream layout in bytes, bank 0 sits below BA1_START
    localparam logic [24:0] BA1_START  = 25'h08_0000;
    localparam logic [24:0] PCM_START  = 25'h09_0000;
    localparam logic [24:0] BA2_START  = 25'h0D_0000;

    // PROMs follow the tile data and never reach the SDRAM
    localparam logic [24:0] MCU_START  = 25'h1B_0000;
    localparam logic [24:0] MCU_END    = MCU_START + 25'h1000;
    localparam logic [24:0] PROM_START = MCU_END;
    // Priority PROM is the second one after the MCU image
    localparam logic [24:0] PRIO_START = PROM_START + 25'h200;
    localparam logic [24:0] PRIO_END   = PRIO_START + 25'h200;

    // ADPCM data position inside bank 1, in words
    localparam sdram_addr_t PCM_OFFSET = sdram_addr_t'((PCM_START - BA1_START) >> 1);

    // Tile graphics regions in bank 2, lengths and offsets in words
    localparam sdram_addr_t GFX1_LEN    = 22'h01_0000;
    localparam sdram_addr_t GFX2_LEN    = 22'h04_0000;
    localparam sdram_addr_t GFX2_OFFSET = 22'h10_0000;
    localparam sdram_addr_t GFX3_OFFSET = 22'h20_0000;

    // Per slot offsets for each bank
    localparam sdram_addr_t SND_SLOT_OFFSET [2] = '{
        22'd0,
        PCM_OFFSET
    };

    localparam sdram_addr_t GFX_SLOT_OFFSET [3] = '{
        22'd0,
        GFX2_OFFSET,
        GFX3_OFFSET
    };

endpackage

`default_nettype wire

// File: design/slot_if.sv
// ROM client slot
`timescale 1ns/1ns
`default_nettype none

interface slot_if
    import sdram_map_pkg::*;
#(
    parameter type payload_t = snd_word_t
);

    // Level, held while the client wants the word
    logic       cs;
    slot_addr_t addr;

    // Last word fetched for this slot
    payload_t   data;
    // High while data belongs to addr
    logic       ok;

    modport client (
        output cs,
        output addr,
        input  data,
        input  ok
    );

    modport bank (
        input  cs,
        input  addr,
        output data,
        output ok
    );

endinterface

`default_nettype wire

// File: design/rom_slot_bank.sv
// ROM slot read arbiter
`timescale 1ns/1ns
`default_nettype none

module rom_slot_bank
    import sdram_map_pkg::*;
#(
    parameter int          SLOTS           = 2,
    parameter type         payload_t       = snd_word_t,
    parameter sdram_addr_t OFFSETS [SLOTS] = '{default: '0}
) (
    input  logic        clk,
    input  logic        rst_n,

    slot_if.bank        slots [SLOTS],

    // SDRAM request port
    output sdram_addr_t sdram_addr,
    output logic        sdram_rd,
    input  logic        sdram_ack,
    input  logic        data_dst,
    input  logic        data_rdy,
    input  logic [15:0] data_read
);

    localparam int IW = (SLOTS > 1) ? $clog2(SLOTS) : 1;
    localparam int PW = $bits(payload_t);

    logic [SLOTS-1:0] slot_cs;
    logic [SLOTS-1:0] hit;
    logic [SLOTS-1:0] miss;
    logic [SLOTS-1:0] fill;
    slot_addr_t       slot_addr [SLOTS];

    logic             busy_q;
    logic [IW-1:0]    sel_q;
    slot_addr_t       req_addr_q;

    logic             pick_any;
    logic [IW-1:0]    pick_idx;
    slot_addr_t       pick_addr;
    sdram_addr_t      pick_word;
    payload_t         fill_word;

    // Lowest numbered slot that misses wins
    always_comb begin
        pick_any = 1'b0;
        pick_idx = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (miss[i]) begin
                pick_any = 1'b1;
                pick_idx = IW'(i);
            end
        end
    end

    assign pick_addr = slot_addr[pick_idx];

    generate
        if (PW == 32) begin : g_wide
            logic [15:0] low_q;

            // First beat is the low half
            always_ff @(posedge clk) begin
                if (busy_q && data_dst) begin
                    low_q <= data_read;
                end
            end

            // Two words per slot address
            assign pick_word = sdram_addr_t'({pick_addr, 1'b0});
            assign fill_word = payload_t'({data_read, low_q});
        end else begin : g_byte
            // Bit 0 picks the byte, even bytes sit in the upper half
            assign pick_word = sdram_addr_t'(pick_addr[19:1]);
            assign fill_word = payload_t'(req_addr_q[0] ? data_read[7:0] : data_read[15:8]);
        end
    endgenerate

    // Request sequencing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            sdram_rd <= 1'b0;
        end else if (!busy_q) begin
            busy_q   <= pick_any;
            sdram_rd <= pick_any;
        end else begin
            if (sdram_ack) begin
                sdram_rd <= 1'b0;
            end
            if (data_rdy) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Selection and address hold until the fetch is over
    always_ff @(posedge clk) begin
        if (!busy_q && pick_any) begin
            sel_q      <= pick_idx;
            req_addr_q <= pick_addr;
            sdram_addr <= OFFSETS[pick_idx] + pick_word;
        end
    end

    for (genvar i = 0; i < SLOTS; i++) begin : g_slot
        logic       valid_q;
        logic       ok_q;
        slot_addr_t addr_q;
        payload_t   data_q;

        assign slot_cs[i]   = slots[i].cs;
        assign slot_addr[i] = slots[i].addr;

        assign hit[i]  = slot_cs[i] && valid_q && slot_addr[i] == addr_q;
        assign miss[i] = slot_cs[i] && !hit[i];
        assign fill[i] = busy_q && data_rdy && sel_q == IW'(i);

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                valid_q <= 1'b0;
                ok_q    <= 1'b0;
            end else begin
                if (fill[i]) begin
                    valid_q <= 1'b1;
                end
                // A fresh word is only good if the client kept its address
                ok_q <= fill[i] ? (slot_cs[i] && slot_addr[i] == req_addr_q) : hit[i];
            end
        end

        always_ff @(posedge clk) begin
            if (fill[i]) begin
                addr_q <= req_addr_q;
                data_q <= fill_word;
            end
        end

        assign slots[i].data = data_q;
        assign slots[i].ok   = ok_q;
    end

    // Back-pressure from the controller must not lose the request
    a_rd_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        sdram_rd && !sdram_ack |=> sdram_rd && $stable(sdram_addr)
    ) else $error("SDRAM read dropped or changed before ack");

    a_no_stray_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        (data_dst || data_rdy) |-> busy_q && !sdram_rd
    ) else $error("SDRAM data arrived without an accepted request");

endmodule

`default_nettype wire

// File: design/dwnld_mapper.sv
// ROM download mapper
`timescale 1ns/1ns
`default_nettype none

module dwnld_mapper
    import sdram_map_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,

    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,

    output sdram_addr_t prog_addr,
    output logic [15:0] prog_data,
    output logic [1:0]  prog_mask,
    output logic [1:0]  prog_ba,
    output logic        prog_we,
    output logic        mcu_we,
    output logic        prio_we,
    input  logic        prog_ack,

    output logic        dwnld_busy
);

    logic [7:0]  even_q;
    logic        word_wr;

    logic        is_prom;
    logic        is_mcu;
    logic        is_prio;
    logic [1:0]  map_ba;
    logic [24:0] bank_start;
    logic [24:0] byte_off;
    sdram_addr_t pre_addr;
    sdram_addr_t gfx2_rel;
    sdram_addr_t gfx3_rel;
    sdram_addr_t map_addr;

    assign word_wr    = downloading && ioctl_wr && ioctl_addr[0];
    assign dwnld_busy = downloading;
    // Both bytes always written, mask is active low
    assign prog_mask  = 2'b00;

    always_comb begin
        is_prom = ioctl_addr >= MCU_START;
        is_mcu  = ioctl_addr >= MCU_START && ioctl_addr < MCU_END;
        is_prio = ioctl_addr >= PRIO_START && ioctl_addr < PRIO_END;

        // Bank choice and the byte where that bank begins
        if (is_prom) begin
            map_ba     = 2'd0;
            bank_start = is_prio ? PRIO_START : MCU_START;
        end else if (ioctl_addr >= BA2_START) begin
            map_ba     = 2'd2;
            bank_start = BA2_START;
        end else if (ioctl_addr >= BA1_START) begin
            map_ba     = 2'd1;
            bank_start = BA1_START;
        end else begin
            map_ba     = 2'd0;
            bank_start = '0;
        end

        byte_off = ioctl_addr - bank_start;
        pre_addr = byte_off[22:1];
        gfx2_rel = pre_addr - GFX1_LEN;
        gfx3_rel = pre_addr - GFX1_LEN - GFX2_LEN;

        // Tile regions are reordered so one 32-bit read gets all four planes
        map_addr = pre_addr;
        if (!is_prom && map_ba == 2'd2) begin
            if (pre_addr < GFX1_LEN) begin
                map_addr = {pre_addr[21:16], pre_addr[14:0], ~pre_addr[15]};
            end else if (gfx2_rel < GFX2_LEN) begin
                map_addr = {GFX2_OFFSET[21:18], gfx2_rel[16:0], gfx2_rel[17]};
            end else begin
                map_addr = {GFX3_OFFSET[21:17], gfx3_rel[15:0], gfx3_rel[16]};
            end
        end
    end

    // Strobes, PROM words pulse for a single cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            mcu_we  <= 1'b0;
            prio_we <= 1'b0;
        end else begin
            mcu_we  <= 1'b0;
            prio_we <= 1'b0;
            if (prog_ack) begin
                prog_we <= 1'b0;
            end
            if (word_wr) begin
                prog_we <= !is_prom;
                mcu_we  <= is_mcu;
                prio_we <= is_prio;
            end
        end
    end

    // Even byte is held, then lands in the upper half of the word
    always_ff @(posedge clk) begin
        if (downloading && ioctl_wr && !ioctl_addr[0]) begin
            even_q <= ioctl_dout;
        end
        if (word_wr) begin
            prog_data <= {even_q, ioctl_dout};
            prog_addr <= map_addr;
            prog_ba   <= map_ba;
        end
    end

    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        prog_we |-> !ioctl_wr
    ) else $error("Download byte arrived while a word was still pending");

endmodule

`default_nettype wire

// File: design/sdram_mapper.sv
// Sound and tile SDRAM mapper
`timescale 1ns/1ns
`default_nettype none

module sdram_mapper
    import sdram_map_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // Sound CPU
    input  logic        snd_cs,
    input  logic [15:0] snd_addr,
    output logic [7:0]  snd_data,
    output logic        snd_ok,

    // ADPCM ROM
    input  logic        adpcm_cs,
    input  logic [17:0] adpcm_addr,
    output logic [7:0]  adpcm_data,
    output logic        adpcm_ok,
    input  logic        sndflag2,

    // Scroll layer ROMs
    input  logic        b0rom_cs,
    input  logic [16:0] b0rom_addr,
    output logic [31:0] b0rom_data,
    output logic        b0rom_ok,
    input  logic        b1rom_cs,
    input  logic [16:0] b1rom_addr,
    output logic [31:0] b1rom_data,
    output logic        b1rom_ok,
    input  logic        b2rom_cs,
    input  logic [16:0] b2rom_addr,
    output logic [31:0] b2rom_data,
    output logic        b2rom_ok,

    // SDRAM banks 1 and 2
    output sdram_addr_t ba1_addr,
    output logic        ba1_rd,
    input  logic        ba1_ack,
    input  logic        ba1_dst,
    input  logic        ba1_rdy,
    output sdram_addr_t ba2_addr,
    output logic        ba2_rd,
    input  logic        ba2_ack,
    input  logic        ba2_dst,
    input  logic        ba2_rdy,
    input  logic [15:0] data_read,

    // ROM download
    input  logic        downloading,
    output logic        dwnld_busy,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    output sdram_addr_t prog_addr,
    output logic [15:0] prog_data,
    output logic [1:0]  prog_mask,
    output logic [1:0]  prog_ba,
    output logic        prog_we,
    output logic        mcu_we,
    output logic        prio_we,
    input  logic        prog_ack
);

    slot_if #(.payload_t(snd_word_t)) snd_slot [2] ();
    slot_if #(.payload_t(gfx_word_t)) gfx_slot [3] ();

    // Sound CPU sees 32 kB, the flag moves ADPCM to its upper half
    assign snd_slot[0].cs   = snd_cs;
    assign snd_slot[0].addr = {5'd0, snd_addr[14:0]};
    assign snd_data         = snd_slot[0].data;
    assign snd_ok           = snd_slot[0].ok;

    assign snd_slot[1].cs   = adpcm_cs;
    assign snd_slot[1].addr = {2'd0, adpcm_addr[17:16], adpcm_addr[15] | sndflag2,
                               adpcm_addr[14:0]};
    assign adpcm_data       = snd_slot[1].data;
    assign adpcm_ok         = snd_slot[1].ok;

    // Layer offsets are applied inside the bank
    assign gfx_slot[0].cs   = b0rom_cs;
    assign gfx_slot[0].addr = {3'd0, b0rom_addr};
    assign b0rom_data       = gfx_slot[0].data;
    assign b0rom_ok         = gfx_slot[0].ok;

    assign gfx_slot[1].cs   = b1rom_cs;
    assign gfx_slot[1].addr = {3'd0, b1rom_addr};
    assign b1rom_data       = gfx_slot[1].data;
    assign b1rom_ok         = gfx_slot[1].ok;

    assign gfx_slot[2].cs   = b2rom_cs;
    assign gfx_slot[2].addr = {3'd0, b2rom_addr};
    assign b2rom_data       = gfx_slot[2].data;
    assign b2rom_ok         = gfx_slot[2].ok;

    rom_slot_bank #(
        .SLOTS     (2),
        .payload_t (snd_word_t),
        .OFFSETS   (SND_SLOT_OFFSET)
    ) u_bank1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .slots      (snd_slot),
        .sdram_addr (ba1_addr),
        .sdram_rd   (ba1_rd),
        .sdram_ack  (ba1_ack),
        .data_dst   (ba1_dst),
        .data_rdy   (ba1_rdy),
        .data_read  (data_read)
    );

    rom_slot_bank #(
        .SLOTS     (3),
        .payload_t (gfx_word_t),
        .OFFSETS   (GFX_SLOT_OFFSET)
    ) u_bank2 (
        .clk        (clk),
        .rst_n      (rst_n),
        .slots      (gfx_slot),
        .sdram_addr (ba2_addr),
        .sdram_rd   (ba2_rd),
        .sdram_ack  (ba2_ack),
        .data_dst   (ba2_dst),
        .data_rdy   (ba2_rdy),
        .data_read  (data_read)
    );

    dwnld_mapper u_dwnld (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_ba     (prog_ba),
        .prog_we     (prog_we),
        .mcu_we      (mcu_we),
        .prio_we     (prio_we),
        .prog_ack    (prog_ack),
        .dwnld_busy  (dwnld_busy)
    );

endmodule

`default_nettype wire

// File: verification/sdram_bank_model.sv
// Behavioural SDRAM model
`timescale 1ns/1ns
`default_nettype none

module sdram_bank_model
    import sdram_map_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h08f8fbe5
) (
    input  logic        clk,
    input  logic        rst_n,
    // Long ack delays when high
    input  logic        slow,

    input  sdram_addr_t ba1_addr,
    input  logic        ba1_rd,
    output logic        ba1_ack,
    output logic        ba1_dst,
    output logic        ba1_rdy,
    input  sdram_addr_t ba2_addr,
    input  logic        ba2_rd,
    output logic        ba2_ack,
    output logic        ba2_dst,
    output logic        ba2_rdy,
    output logic [15:0] data_read,

    input  sdram_addr_t prog_addr,
    input  logic [15:0] prog_data,
    input  logic [1:0]  prog_ba,
    input  logic        prog_we,
    output logic        prog_ack,
    output int unsigned write_count
);

    logic [15:0] mem [int];
    logic [31:0] rnd;
    logic [1:0]  state;
    logic        port2;
    int          wait_n;
    int          key;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Unwritten words hold a hash of their full address
    function automatic logic [15:0] fill_word(input int k);
        logic [31:0] h;
        h = k * 32'h9e3779b1;
        return h[31:16] ^ h[15:0];
    endfunction

    function automatic logic [15:0] read_word(input int k);
        if (mem.exists(k)) begin
            return mem[k];
        end
        return fill_word(k);
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            state       <= 2'd0;
            port2       <= 1'b0;
            {ba1_ack, ba1_dst, ba1_rdy} <= 3'b000;
            {ba2_ack, ba2_dst, ba2_rdy} <= 3'b000;
            prog_ack    <= 1'b0;
            write_count <= 0;
            data_read   <= '0;
            rnd = SEED;
        end else begin
            {ba1_ack, ba1_dst, ba1_rdy} <= 3'b000;
            {ba2_ack, ba2_dst, ba2_rdy} <= 3'b000;
            prog_ack <= 1'b0;
            if (prog_we && !prog_ack) begin
                mem[int'({prog_ba, prog_addr})] = prog_data;
                prog_ack    <= 1'b1;
                write_count <= write_count + 1;
            end
            case (state)
                2'd0: if (ba1_rd || ba2_rd) begin
                    // Alternate when both banks ask
                    port2  <= ba2_rd && (!ba1_rd || !port2);
                    rnd = xorshift32(rnd);
                    wait_n <= slow ? 6 + int'(rnd % 10) : int'(rnd % 6);
                    state  <= 2'd1;
                end
                2'd1: if (wait_n == 0) begin
                    ba1_ack <= !port2;
                    ba2_ack <= port2;
                    key     <= port2 ? int'({2'd2, ba2_addr}) : int'({2'd1, ba1_addr});
                    state   <= 2'd2;
                end else begin
                    wait_n <= wait_n - 1;
                end
                2'd2: begin
                    data_read <= read_word(key);
                    if (port2) begin
                        ba2_dst <= 1'b1;
                        key     <= key + 1;
                        state   <= 2'd3;
                    end else begin
                        ba1_dst <= 1'b1;
                        ba1_rdy <= 1'b1;
                        state   <= 2'd0;
                    end
                end
                default: begin
                    data_read <= read_word(key);
                    ba2_rdy   <= 1'b1;
                    state     <= 2'd0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_sdram_mapper.sv
// SDRAM mapper testbench
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_mapper
    import sdram_map_pkg::*;
();

    // About 110 download words and 375 reads, each well under 40 cycles
    localparam int MAX_CYCLES = 20000;

    logic        clk;
    logic        rst_n;
    logic        slow;
    logic [4:0]  cli_cs;
    logic [17:0] cli_addr [5];
    logic [4:0]  cli_ok;
    logic [31:0] cli_data [5];
    logic        sndflag2;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;

    logic [7:0]  snd_data;
    logic [7:0]  adpcm_data;
    sdram_addr_t ba1_addr;
    sdram_addr_t ba2_addr;
    sdram_addr_t prog_addr;
    logic        ba1_rd, ba1_ack, ba1_dst, ba1_rdy;
    logic        ba2_rd, ba2_ack, ba2_dst, ba2_rdy;
    logic [15:0] data_read;
    logic [15:0] prog_data;
    logic [1:0]  prog_mask;
    logic [1:0]  prog_ba;
    logic        prog_we, mcu_we, prio_we, prog_ack, dwnld_busy;
    int unsigned write_count;

    logic [15:0] written [int];
    logic [31:0] rnd;
    int          errors;
    int          reads;
    int          cycles;
    int          exp_writes;
    string       slot_name [5] = '{"snd_data", "adpcm_data", "b0rom_data",
                                   "b1rom_data", "b2rom_data"};

    assign cli_data[0] = {24'd0, snd_data};
    assign cli_data[1] = {24'd0, adpcm_data};

    sdram_mapper uut (
        .clk (clk), .rst_n (rst_n),
        .snd_cs (cli_cs[0]), .snd_addr (cli_addr[0][15:0]),
        .snd_data (snd_data), .snd_ok (cli_ok[0]),
        .adpcm_cs (cli_cs[1]), .adpcm_addr (cli_addr[1]),
        .adpcm_data (adpcm_data), .adpcm_ok (cli_ok[1]), .sndflag2 (sndflag2),
        .b0rom_cs (cli_cs[2]), .b0rom_addr (cli_addr[2][16:0]),
        .b0rom_data (cli_data[2]), .b0rom_ok (cli_ok[2]),
        .b1rom_cs (cli_cs[3]), .b1rom_addr (cli_addr[3][16:0]),
        .b1rom_data (cli_data[3]), .b1rom_ok (cli_ok[3]),
        .b2rom_cs (cli_cs[4]), .b2rom_addr (cli_addr[4][16:0]),
        .b2rom_data (cli_data[4]), .b2rom_ok (cli_ok[4]),
        .ba1_addr (ba1_addr), .ba1_rd (ba1_rd), .ba1_ack (ba1_ack),
        .ba1_dst (ba1_dst), .ba1_rdy (ba1_rdy),
        .ba2_addr (ba2_addr), .ba2_rd (ba2_rd), .ba2_ack (ba2_ack),
        .ba2_dst (ba2_dst), .ba2_rdy (ba2_rdy), .data_read (data_read),
        .downloading (downloading), .dwnld_busy (dwnld_busy),
        .ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout), .ioctl_wr (ioctl_wr),
        .prog_addr (prog_addr), .prog_data (prog_data), .prog_mask (prog_mask),
        .prog_ba (prog_ba), .prog_we (prog_we), .mcu_we (mcu_we),
        .prio_we (prio_we), .prog_ack (prog_ack)
    );

    sdram_bank_model u_model (
        .clk (clk), .rst_n (rst_n), .slow (slow),
        .ba1_addr (ba1_addr), .ba1_rd (ba1_rd), .ba1_ack (ba1_ack),
        .ba1_dst (ba1_dst), .ba1_rdy (ba1_rdy),
        .ba2_addr (ba2_addr), .ba2_rd (ba2_rd), .ba2_ack (ba2_ack),
        .ba2_dst (ba2_dst), .ba2_rdy (ba2_rdy), .data_read (data_read),
        .prog_addr (prog_addr), .prog_data (prog_data), .prog_ba (prog_ba),
        .prog_we (prog_we), .prog_ack (prog_ack), .write_count (write_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [15:0] fill_word(input int k);
        logic [31:0] h;
        h = k * 32'h9e3779b1;
        return h[31:16] ^ h[15:0];
    endfunction

    function automatic logic [15:0] mem_word(input logic [1:0] ba, input sdram_addr_t w);
        int k;
        k = int'({ba, w});
        if (written.exists(k)) begin
            return written[k];
        end
        return fill_word(k);
    endfunction

    // Bank for a download byte, 3 marks the PROM area
    function automatic logic [1:0] ref_bank(input logic [24:0] a);
        if (a >= MCU_START) return 2'd3;
        if (a >= BA2_START) return 2'd2;
        if (a >= BA1_START) return 2'd1;
        return 2'd0;
    endfunction

    function automatic sdram_addr_t ref_addr(input logic [24:0] a);
        logic [24:0] w;
        logic [24:0] rel;
        if (a >= BA2_START) begin
            w = (a - BA2_START) >> 1;
            if (w < GFX1_LEN) return {w[21:16], w[14:0], ~w[15]};
            rel = w - GFX1_LEN;
            if (rel < GFX2_LEN) return GFX2_OFFSET + sdram_addr_t'({rel[16:0], rel[17]});
            rel = rel - GFX2_LEN;
            return GFX3_OFFSET + sdram_addr_t'({rel[15:0], rel[16]});
        end
        if (a >= BA1_START) return sdram_addr_t'((a - BA1_START) >> 1);
        return sdram_addr_t'(a >> 1);
    endfunction

    // Expected {mcu_we, prio_we}
    function automatic logic [1:0] ref_strobes(input logic [24:0] a);
        return {a >= MCU_START && a < MCU_END, a >= PRIO_START && a < PRIO_END};
    endfunction

    function automatic logic [31:0] expect_slot(input int s, input logic [17:0] a,
                                                input logic flag);
        logic [17:0] sa;
        sdram_addr_t w;
        logic [15:0] hw;
        if (s >= 2) begin
            w = GFX_SLOT_OFFSET[s-2] + sdram_addr_t'({a[16:0], 1'b0});
            return {mem_word(2'd2, w + 1), mem_word(2'd2, w)};
        end
        sa = (s == 0) ? {3'd0, a[14:0]} : {a[17:16], a[15] | flag, a[14:0]};
        w  = ((s == 0) ? 22'd0 : PCM_OFFSET) + sdram_addr_t'(sa[17:1]);
        hw = mem_word(2'd1, w);
        return {24'd0, sa[0] ? hw[7:0] : hw[15:8]};
    endfunction

    function automatic logic [17:0] rand_addr(input int s);
        rnd = xorshift32(rnd);
        // Small addresses land on downloaded words
        if (rnd[31:30] == 2'd0) return {13'd0, rnd[4:0]};
        if (s == 0) return {2'd0, rnd[15:0]};
        if (s == 1) return rnd[17:0];
        return {1'b0, rnd[16:0]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Output comparison against the address seen at the last edge
    logic [4:0]  seen_cs;
    logic [17:0] seen_addr [5];
    logic        seen_flag;

    always @(posedge clk) begin
        seen_cs   <= cli_cs;
        seen_addr <= cli_addr;
        seen_flag <= sndflag2;
    end

    always @(negedge clk) begin : compare_outputs
        logic [31:0] want;
        if (rst_n) begin
            if (dwnld_busy !== downloading) begin
                $display("Mismatch dwnld_busy exp %h got %h", downloading, dwnld_busy);
                errors++;
            end
            for (int s = 0; s < 5; s++) begin
                if (cli_ok[s] && !seen_cs[s]) begin
                    $display("Slot %s showed ok without chip select", slot_name[s]);
                    errors++;
                end else if (cli_ok[s]) begin
                    want = expect_slot(s, seen_addr[s], seen_flag);
                    if (cli_data[s] !== want) begin
                        $display("Mismatch %s exp %h got %h", slot_name[s], want, cli_data[s]);
                        errors++;
                    end
                end
            end
        end
    end

    task automatic put_byte(input logic [24:0] a, input logic [7:0] d);
        @(posedge clk);
        #10;
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #10;
        ioctl_wr = 1'b0;
    endtask

    task automatic download_word(input logic [24:0] a, input logic [15:0] w);
        logic [1:0] ba;
        logic [1:0] strobes;
        ba      = ref_bank(a);
        strobes = ref_strobes(a);
        put_byte(a, w[15:8]);
        put_byte(a + 1, w[7:0]);
        @(negedge clk);
        if ({mcu_we, prio_we} !== strobes) begin
            $display("Mismatch mcu_we,prio_we exp %h got %h", strobes, {mcu_we, prio_we});
            errors++;
        end
        if (ba == 2'd3) begin
            if (prog_we !== 1'b0) begin
                $display("PROM byte at %h started an SDRAM write", a);
                errors++;
            end
        end else if (prog_we !== 1'b1) begin
            $display("prog_we did not rise after the odd byte at %h", a + 1);
            errors++;
        end else begin
            if (prog_addr !== ref_addr(a)) begin
                $display("Mismatch prog_addr exp %h got %h", ref_addr(a), prog_addr);
                errors++;
            end
            if (prog_data !== w) begin
                $display("Mismatch prog_data exp %h got %h", w, prog_data);
                errors++;
            end
            if (prog_ba !== ba) begin
                $display("Mismatch prog_ba exp %h got %h", ba, prog_ba);
                errors++;
            end
            // Whole words are written, the mask is active low
            if (prog_mask !== 2'b00) begin
                $display("Mismatch prog_mask exp %h got %h", 2'b00, prog_mask);
                errors++;
            end
            written[int'({ba, ref_addr(a)})] = w;
            exp_writes++;
            while (prog_we) @(negedge clk);
        end
    endtask

    task automatic download_range(input logic [24:0] start, input int nbytes);
        for (int i = 0; i < nbytes; i += 2) begin
            rnd = xorshift32(rnd);
            download_word(start + 25'(i), rnd[15:0]);
        end
    endtask

    // Clients take a new address after each ok, and may give up under long delays
    task automatic run_reads(input int per_slot, input logic long_delay);
        int left [5];
        int age [5];
        int pending;
        logic [4:0] got_ok;
        @(posedge clk);
        #10;
        slow = long_delay;
        for (int s = 0; s < 5; s++) begin
            left[s]     = per_slot;
            age[s]      = 0;
            cli_addr[s] = rand_addr(s);
            cli_cs[s]   = 1'b1;
        end
        pending = 5;
        while (pending > 0) begin
            @(negedge clk);
            got_ok = cli_ok;
            @(posedge clk);
            #10;
            for (int s = 0; s < 5; s++) begin
                if (left[s] > 0 && got_ok[s] && age[s] > 0) begin
                    left[s]--;
                    reads++;
                    age[s]      = 0;
                    cli_addr[s] = rand_addr(s);
                    if (left[s] == 0) begin
                        cli_cs[s] = 1'b0;
                        pending--;
                    end
                end else if (left[s] > 0) begin
                    age[s]++;
                    rnd = xorshift32(rnd);
                    if (long_delay && age[s] == 3 && rnd[1:0] == 2'd0) begin
                        cli_addr[s] = rand_addr(s);
                        age[s]      = 0;
                    end
                end
            end
        end
        slow = 1'b0;
    endtask

    task automatic check_hit(input int s);
        @(posedge clk);
        #10;
        cli_addr[s] = rand_addr(s);
        cli_cs[s]   = 1'b1;
        @(posedge clk);
        @(negedge clk);
        while (!cli_ok[s]) @(negedge clk);
        @(posedge clk);
        #10;
        cli_cs[s] = 1'b0;
        @(posedge clk);
        #10;
        cli_cs[s] = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (!cli_ok[s]) begin
            $display("Repeated address on %s gave no ok one cycle after cs", slot_name[s]);
            errors++;
        end
        @(posedge clk);
        #10;
        cli_cs[s] = 1'b0;
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped at the %0d cycle limit with the DUT still busy", MAX_CYCLES);
        $display("Errors: %0d, reads: %0d", errors, reads);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        slow        = 1'b0;
        cli_cs      = '0;
        cli_addr    = '{default: '0};
        sndflag2    = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        rnd         = 32'h08f8fbe5;
        errors      = 0;
        reads       = 0;
        exp_writes  = 0;
        repeat (8) @(posedge clk);
        #10;
        rst_n       = 1'b1;
        downloading = 1'b1;

        // Bank edges, region edges and both PROMs
        download_range(25'h100, 16);
        download_range(BA1_START - 4, 72);
        download_range(PCM_START, 16);
        download_range(BA2_START - 4, 36);
        download_range(BA2_START + 2 * GFX1_LEN - 8, 16);
        download_range(BA2_START + 2 * (GFX1_LEN + GFX2_LEN) - 8, 16);
        download_range(MCU_START, 16);
        download_range(PRIO_START - 4, 8);
        download_range(PRIO_END - 4, 8);
        @(posedge clk);
        #10;
        downloading = 1'b0;
        if (write_count != exp_writes) begin
            $display("Mismatch write_count exp %h got %h", exp_writes, write_count);
            errors++;
        end

        run_reads(30, 1'b0);
        sndflag2 = 1'b1;
        run_reads(30, 1'b0);
        run_reads(15, 1'b1);
        for (int s = 0; s < 5; s++) begin
            check_hit(s);
        end

        repeat (4) @(posedge clk);
        $display("Errors: %0d, reads: %0d", errors, reads);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
design/sdram_map_pkg.sv
design/slot_if.sv
design/rom_slot_bank.sv
design/dwnld_mapper.sv
design/sdram_mapper.sv
verification/sdram_bank_model.sv
verification/tb_sdram_mapper.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_sdram_mapper
FILELIST  := sim.f
FLAGS     := --binary --timing --assert -sv
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -sv --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
